/* tx_rf_subsys.f */
tx_rf_pkg.sv
tx_iq_fifo.sv
tx_on_detection.sv
tx_frame_sequencer.sv
dac_frontend.sv
tx_rf_subsys.sv
tb_tx_rf_subsys.sv

/* Makefile */
TOP = tb_tx_rf_subsys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f tx_rf_subsys.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f tx_rf_subsys.f

clean:
	rm -rf obj_dir

/* tb_tx_rf_subsys.sv */
// testbench for the tx rf timing subsystem, streams random frames and checks data and timing
`timescale 1ns/1ps
`default_nettype none

module tb_tx_rf_subsys import tx_rf_pkg::*; ();

    localparam int SEED = 32'h9a72_ce4e;
    localparam int NUM_FRAMES = 6;
    localparam int MIN_LEN = 20;
    localparam int MAX_LEN = 40;
    localparam int MAX_GAP = 3;
    localparam int MAX_DELAY_SUM = (4 + 7) * COUNT_SCALE;
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * (MAX_LEN * (MAX_GAP + 1) + MAX_DELAY_SUM) + 200;
    // clocks the bb window stays open past its internal end
    localparam int BB_HOLD = 4;

    logic                           clk;
    logic                           rstn;
    logic                           tx_req;
    logic [LEN_W-1:0]               tx_len;
    logic                           tx_ack;
    logic                           sample_valid;
    logic                           sample_ready;
    logic [NUM_CHAINS*SAMPLE_W-1:0] sample_data;
    logic [7:0]                     bb_rf_delay;
    logic [6:0]                     rf_end_ext;
    logic [6:0]                     chain_on_delay;
    logic [6:0]                     chain_off_delay;
    logic [NUM_CHAINS-1:0]          dac_valid;
    logic [NUM_CHAINS*SAMPLE_W-1:0] dac_data;
    logic [NUM_CHAINS-1:0]          pa_en;
    logic [NUM_CHAINS-1:0]          tx_bb_is_ongoing;
    logic                           tx_core_is_ongoing;

    // samples sent but not yet seen on the DAC side
    logic [NUM_CHAINS*SAMPLE_W-1:0] exp_q[$];
    logic [NUM_CHAINS*SAMPLE_W-1:0] dac_word;

    int errors = 0;
    int cyc = 0;
    int cur_len = 0;
    int frames_done = 0;
    int total_beats = 0;

    // edge cycles of the current frame stay at -1 until seen
    int first_dv = -1;
    int last_fall = -1;
    int rf_rise = -1;
    int rf_fall = -1;
    int pa_rise = -1;
    int pa_fall = -1;
    int bb_rise = -1;
    int bb_fall = -1;
    int core_rise = -1;
    int core_fall = -1;
    int req_rise = -1;
    int edge_cnt = 0;
    int beats = 0;
    logic dv_q = 1'b0;
    logic busy_q = 1'b0;
    logic pa_q = 1'b0;
    logic bb_q = 1'b0;
    logic core_q = 1'b0;
    logic req_q = 1'b0;
    logic ack_q = 1'b0;

    tx_rf_subsys uut (
        .clk                (clk),
        .rstn               (rstn),
        .tx_req             (tx_req),
        .tx_len             (tx_len),
        .tx_ack             (tx_ack),
        .sample_valid       (sample_valid),
        .sample_ready       (sample_ready),
        .sample_data        (sample_data),
        .bb_rf_delay        (bb_rf_delay),
        .rf_end_ext         (rf_end_ext),
        .chain_on_delay     (chain_on_delay),
        .chain_off_delay    (chain_off_delay),
        .dac_valid          (dac_valid),
        .dac_data           (dac_data),
        .pa_en              (pa_en),
        .tx_bb_is_ongoing   (tx_bb_is_ongoing),
        .tx_core_is_ongoing (tx_core_is_ongoing)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic report_mismatch(input string what, input int got, input int want);
        errors++;
        $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, want);
    endtask

    // expected rf_busy and pa_en edge cycles of one frame
    // first is the cycle dac_valid first rose, last the cycle it finally fell
    function automatic void expected_windows(input int first, input int last,
                                             output int rf_rise_x, output int rf_fall_x,
                                             output int pa_rise_x, output int pa_fall_x);
        int d;
        int e;
        int con;
        int coff;
        int rf_on;
        int rf_off;
        int ch_on;
        int ch_off;
        d    = int'(bb_rf_delay) * COUNT_SCALE;
        e    = int'(rf_end_ext) * COUNT_SCALE;
        con  = int'(chain_on_delay) * COUNT_SCALE;
        coff = int'(chain_off_delay) * COUNT_SCALE;
        // bb start pulse lands with the first dac beat, windows open delay + 2 after it
        rf_on = first + d + 2;
        ch_on = first + con + 2;
        // bb end pulse follows the fifo running dry, windows close delay + 2 after it
        rf_off = last + d + e + 2;
        ch_off = last + coff + 2;
        // front end registers both windows
        rf_rise_x = rf_on + 1;
        rf_fall_x = rf_off + 1;
        pa_rise_x = ((rf_on > ch_on) ? rf_on : ch_on) + 1;
        pa_fall_x = ((rf_off < ch_off) ? rf_off : ch_off) + 1;
    endfunction

    task automatic check_frame();
        int x_rf_rise;
        int x_rf_fall;
        int x_pa_rise;
        int x_pa_fall;
        assert (tx_req) else begin
            errors++;
            $display("error at %0t: tx_ack rose while tx_req was low", $time);
        end
        assert (beats == cur_len) else report_mismatch("dac beats in frame", beats, cur_len);
        expected_windows(first_dv, last_fall, x_rf_rise, x_rf_fall, x_pa_rise, x_pa_fall);
        assert (edge_cnt == 8) else report_mismatch("window edges", edge_cnt, 8);
        assert (rf_rise == x_rf_rise) else report_mismatch("rf_busy rise", rf_rise, x_rf_rise);
        assert (rf_fall == x_rf_fall) else report_mismatch("rf_busy fall", rf_fall, x_rf_fall);
        assert (pa_rise == x_pa_rise) else report_mismatch("pa_en rise", pa_rise, x_pa_rise);
        assert (pa_fall == x_pa_fall) else report_mismatch("pa_en fall", pa_fall, x_pa_fall);
        // bb window opens with the start pulse and outlasts the end pulse by BB_HOLD clocks
        assert (bb_rise == first_dv)
            else report_mismatch("tx_bb_is_ongoing rise", bb_rise, first_dv);
        assert (bb_fall == last_fall + BB_HOLD)
            else report_mismatch("tx_bb_is_ongoing fall", bb_fall, last_fall + BB_HOLD);
        // core window opens with phy_tx_start, one clock after the request
        assert (core_rise == req_rise + 1)
            else report_mismatch("tx_core_is_ongoing rise", core_rise, req_rise + 1);
        // phy_tx_done closes it during the last dac beat
        assert (core_fall == last_fall - 1)
            else report_mismatch("tx_core_is_ongoing fall", core_fall, last_fall - 1);
        // sequencer acks on the clock after it sees rf_busy low
        assert (cyc == rf_fall + 1) else report_mismatch("tx_ack rise", cyc, rf_fall + 1);
        frames_done++;
        total_beats += beats;
        first_dv  = -1;
        last_fall = -1;
        rf_rise   = -1;
        rf_fall   = -1;
        pa_rise   = -1;
        pa_fall   = -1;
        bb_rise   = -1;
        bb_fall   = -1;
        core_rise = -1;
        core_fall = -1;
        req_rise  = -1;
        edge_cnt  = 0;
        beats     = 0;
    endtask

    // comparator sampling outputs on the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (|dac_valid) begin
                assert (dac_valid == {NUM_CHAINS{1'b1}})
                    else report_mismatch("dac_valid lanes", int'(dac_valid),
                                         (1 << NUM_CHAINS) - 1);
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("error at %0t: DAC beat with no sample outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    dac_word = exp_q.pop_front();
                    for (int c = 0; c < NUM_CHAINS; c++) begin
                        assert (dac_data[c*SAMPLE_W +: SAMPLE_W]
                                == dac_word[c*SAMPLE_W +: SAMPLE_W])
                            else report_mismatch("dac_data",
                                                 int'(dac_data[c*SAMPLE_W +: SAMPLE_W]),
                                                 int'(dac_word[c*SAMPLE_W +: SAMPLE_W]));
                    end
                end
                beats++;
            end
            if (dac_valid[0] && !dv_q && first_dv < 0) begin
                first_dv = cyc;
            end
            if (!dac_valid[0] && dv_q) begin
                last_fall = cyc;
            end
            assert (pa_en == {NUM_CHAINS{pa_en[0]}})
                else report_mismatch("pa_en lanes", int'(pa_en),
                                     pa_en[0] ? (1 << NUM_CHAINS) - 1 : 0);
            assert (tx_bb_is_ongoing == {NUM_CHAINS{tx_bb_is_ongoing[0]}})
                else report_mismatch("tx_bb_is_ongoing lanes", int'(tx_bb_is_ongoing),
                                     tx_bb_is_ongoing[0] ? (1 << NUM_CHAINS) - 1 : 0);
            if (tx_req && !req_q) begin
                req_rise = cyc;
            end
            if (uut.rf_busy != busy_q) begin
                edge_cnt++;
                if (uut.rf_busy) begin
                    rf_rise = cyc;
                end else begin
                    rf_fall = cyc;
                end
            end
            if (pa_en[0] != pa_q) begin
                edge_cnt++;
                if (pa_en[0]) begin
                    pa_rise = cyc;
                end else begin
                    pa_fall = cyc;
                end
            end
            if (tx_bb_is_ongoing[0] != bb_q) begin
                edge_cnt++;
                if (tx_bb_is_ongoing[0]) begin
                    bb_rise = cyc;
                end else begin
                    bb_fall = cyc;
                end
            end
            if (tx_core_is_ongoing != core_q) begin
                edge_cnt++;
                if (tx_core_is_ongoing) begin
                    core_rise = cyc;
                end else begin
                    core_fall = cyc;
                end
            end
            if (tx_ack && !ack_q) begin
                check_frame();
            end
            if (!tx_ack && ack_q) begin
                assert (!tx_req) else begin
                    errors++;
                    $display("error at %0t: tx_ack dropped before tx_req dropped", $time);
                end
            end
        end
        dv_q   = dac_valid[0];
        busy_q = uut.rf_busy;
        pa_q   = pa_en[0];
        bb_q   = tx_bb_is_ongoing[0];
        core_q = tx_core_is_ongoing;
        req_q  = tx_req;
        ack_q  = tx_ack;
    end

    // one frame over the four-phase request, with optional random valid gaps
    task automatic send_frame(input int len, input bit stall);
        logic [NUM_CHAINS*SAMPLE_W-1:0] word;
        int gap;
        cur_len = len;
        tx_len  = LEN_W'(len);
        tx_req  = 1'b1;
        for (int k = 0; k < len; k++) begin
            gap = stall ? int'($urandom_range(0, MAX_GAP)) : 0;
            sample_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            for (int c = 0; c < NUM_CHAINS; c++) begin
                word[c*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($urandom);
            end
            sample_valid = 1'b1;
            sample_data  = word;
            @(negedge clk);
            while (!sample_ready) begin
                @(posedge clk);
                #1;
                @(negedge clk);
            end
            exp_q.push_back(word);
            @(posedge clk);
            #1;
        end
        sample_valid = 1'b0;
        @(negedge clk);
        while (!tx_ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        tx_req = 1'b0;
        @(negedge clk);
        while (tx_ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(SEED));
        rstn            = 1'b0;
        tx_req          = 1'b0;
        tx_len          = '0;
        sample_valid    = 1'b0;
        sample_data     = '0;
        bb_rf_delay     = '0;
        rf_end_ext      = '0;
        chain_on_delay  = '0;
        chain_off_delay = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        @(negedge clk);
        assert (!tx_ack && !sample_ready && dac_valid == '0 && pa_en == '0
                && tx_bb_is_ongoing == '0 && !tx_core_is_ongoing) else begin
            errors++;
            $display("error at %0t: top level outputs not idle after reset", $time);
        end
        assert (!uut.phy_tx_start && !uut.phy_tx_started && !uut.phy_tx_done
                && !uut.fifo_wr && uut.fifo_rd == '0 && !uut.rf_busy
                && uut.tx_rf_is_ongoing == '0 && uut.tx_chain_on == '0) else begin
            errors++;
            $display("error at %0t: internal strobes not idle after reset", $time);
        end
        @(posedge clk);
        #1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            // short delays so both windows open, chain closes no later than rf
            bb_rf_delay     = 8'($urandom_range(0, 4));
            rf_end_ext      = 7'($urandom_range(0, 7));
            chain_on_delay  = 7'($urandom_range(0, 4));
            chain_off_delay = 7'($urandom_range(0, int'(bb_rf_delay) + int'(rf_end_ext)));
            // let the detector thresholds settle
            repeat (3) @(posedge clk);
            #1;
            send_frame((f == 0) ? MAX_LEN : int'($urandom_range(MIN_LEN, MAX_LEN)), f[0]);
        end
        repeat (5) @(posedge clk);

        assert (frames_done == NUM_FRAMES) else begin
            errors++;
            $display("error at %0t: only %0d of %0d frames completed", $time, frames_done,
                     NUM_FRAMES);
        end
        $display("errors: %0d, frames checked: %0d, dac beats: %0d", errors, frames_done,
                 total_beats);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from frame count, longest stalled frame and largest delays
    initial begin
        repeat (WATCHDOG_CYCLES + 10) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d, frames checked: %0d", errors, frames_done);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tx_rf_subsys.sv */
// top level of the tx rf timing subsystem with one FIFO and detector pair per chain
`timescale 1ns/1ps
`default_nettype none

module tx_rf_subsys import tx_rf_pkg::*; (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           tx_req,
    input  logic [LEN_W-1:0]               tx_len,
    output logic                           tx_ack,
    input  logic                           sample_valid,
    output logic                           sample_ready,
    input  logic [NUM_CHAINS*SAMPLE_W-1:0] sample_data,
    input  logic [7:0]                     bb_rf_delay,
    input  logic [6:0]                     rf_end_ext,
    input  logic [6:0]                     chain_on_delay,
    input  logic [6:0]                     chain_off_delay,
    output logic [NUM_CHAINS-1:0]          dac_valid,
    output logic [NUM_CHAINS*SAMPLE_W-1:0] dac_data,
    output logic [NUM_CHAINS-1:0]          pa_en,
    output logic [NUM_CHAINS-1:0]          tx_bb_is_ongoing,
    output logic                           tx_core_is_ongoing
);

    logic                           phy_tx_start;
    logic                           phy_tx_started;
    logic                           phy_tx_done;
    logic                           fifo_wr;
    logic [NUM_CHAINS*SAMPLE_W-1:0] fifo_wdata;
    logic [NUM_CHAINS-1:0]          fifo_rd;
    logic [NUM_CHAINS*SAMPLE_W-1:0] fifo_rdata;
    logic [NUM_CHAINS-1:0]          fifo_empty;
    logic [NUM_CHAINS-1:0]          fifo_full;
    logic [NUM_CHAINS-1:0]          tx_rf_is_ongoing;
    logic [NUM_CHAINS-1:0]          tx_chain_on;
    logic [NUM_CHAINS-1:0]          core_on;
    logic                           rf_busy;

    // every chain sees the same phy events, so any of them reports the core window
    assign tx_core_is_ongoing = |core_on;

    tx_frame_sequencer u_seq (
        .clk            (clk),
        .rstn           (rstn),
        .tx_req         (tx_req),
        .tx_len         (tx_len),
        .tx_ack         (tx_ack),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_data    (sample_data),
        .fifo_full      (fifo_full),
        .rf_busy        (rf_busy),
        .phy_tx_start   (phy_tx_start),
        .phy_tx_started (phy_tx_started),
        .phy_tx_done    (phy_tx_done),
        .fifo_wr        (fifo_wr),
        .fifo_wdata     (fifo_wdata)
    );

    for (genvar i = 0; i < NUM_CHAINS; i++) begin : g_chain
        tx_iq_fifo u_fifo (
            .clk   (clk),
            .rstn  (rstn),
            .wr    (fifo_wr),
            .wdata (fifo_wdata[i*SAMPLE_W +: SAMPLE_W]),
            .rd    (fifo_rd[i]),
            .rdata (fifo_rdata[i*SAMPLE_W +: SAMPLE_W]),
            .empty (fifo_empty[i]),
            .full  (fifo_full[i])
        );

        tx_on_detection u_det (
            .clk                (clk),
            .rstn               (rstn),
            .bb_rf_delay        (bb_rf_delay),
            .rf_end_ext         (rf_end_ext),
            .chain_on_delay     (chain_on_delay),
            .chain_off_delay    (chain_off_delay),
            .phy_tx_start       (phy_tx_start),
            .phy_tx_started     (phy_tx_started),
            .phy_tx_done        (phy_tx_done),
            .tx_iq_fifo_empty   (fifo_empty[i]),
            .tx_core_is_ongoing (core_on[i]),
            .tx_bb_is_ongoing   (tx_bb_is_ongoing[i]),
            .tx_rf_is_ongoing   (tx_rf_is_ongoing[i]),
            .tx_chain_on        (tx_chain_on[i]),
            .pulse_tx_bb_end    ()
        );
    end

    dac_frontend u_dac (
        .clk              (clk),
        .rstn             (rstn),
        .fifo_empty       (fifo_empty),
        .fifo_rdata       (fifo_rdata),
        .tx_rf_is_ongoing (tx_rf_is_ongoing),
        .tx_chain_on      (tx_chain_on),
        .fifo_rd          (fifo_rd),
        .dac_valid        (dac_valid),
        .dac_data         (dac_data),
        .pa_en            (pa_en),
        .rf_busy          (rf_busy)
    );

endmodule

`default_nettype wire

/* dac_frontend.sv */
// DAC front end draining the chain FIFOs and gating the power amplifiers from the chain windows
`timescale 1ns/1ps
`default_nettype none

module dac_frontend import tx_rf_pkg::*; (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [NUM_CHAINS-1:0]          fifo_empty,
    input  logic [NUM_CHAINS*SAMPLE_W-1:0] fifo_rdata,
    input  logic [NUM_CHAINS-1:0]          tx_rf_is_ongoing,
    input  logic [NUM_CHAINS-1:0]          tx_chain_on,
    output logic [NUM_CHAINS-1:0]          fifo_rd,
    output logic [NUM_CHAINS-1:0]          dac_valid,
    output logic [NUM_CHAINS*SAMPLE_W-1:0] dac_data,
    output logic [NUM_CHAINS-1:0]          pa_en,
    output logic                           rf_busy
);

    // one sample per clock whenever a chain has data
    assign fifo_rd = ~fifo_empty;

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHAINS; i++) begin
            if (fifo_rd[i]) begin
                dac_data[i*SAMPLE_W +: SAMPLE_W] <= fifo_rdata[i*SAMPLE_W +: SAMPLE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dac_valid <= '0;
            pa_en     <= '0;
            rf_busy   <= 1'b0;
        end else begin
            dac_valid <= fifo_rd;
            // amplifier only while both rf and chain windows are open
            pa_en     <= tx_rf_is_ongoing & tx_chain_on;
            rf_busy   <= |tx_rf_is_ongoing;
        end
    end

endmodule

`default_nettype wire

/* tx_frame_sequencer.sv */
// frame sequencer taking host req/ack and samples, issuing phy events and FIFO writes
`timescale 1ns/1ps
`default_nettype none

module tx_frame_sequencer import tx_rf_pkg::*; (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           tx_req,
    input  logic [LEN_W-1:0]               tx_len,
    output logic                           tx_ack,
    input  logic                           sample_valid,
    output logic                           sample_ready,
    input  logic [NUM_CHAINS*SAMPLE_W-1:0] sample_data,
    input  logic [NUM_CHAINS-1:0]          fifo_full,
    input  logic                           rf_busy,
    output logic                           phy_tx_start,
    output logic                           phy_tx_started,
    output logic                           phy_tx_done,
    output logic                           fifo_wr,
    output logic [NUM_CHAINS*SAMPLE_W-1:0] fifo_wdata
);

    logic [2:0]       state;
    logic [LEN_W-1:0] remaining;
    logic [CNT_W-1:0] wait_cnt;
    logic             busy_seen;
    logic             beat;

    // any full chain stalls intake for all chains
    assign sample_ready = (state == SEQ_DATA) && (remaining != '0) && !(|fifo_full);
    assign beat         = sample_valid && sample_ready;

    // one write strobe for all chains, each takes its own slice
    assign fifo_wr    = beat;
    assign fifo_wdata = sample_data;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state          <= SEQ_IDLE;
            tx_ack         <= 1'b0;
            phy_tx_start   <= 1'b0;
            phy_tx_started <= 1'b0;
            phy_tx_done    <= 1'b0;
            remaining      <= '0;
            wait_cnt       <= '0;
            busy_seen      <= 1'b0;
        end else begin
            phy_tx_start   <= 1'b0;
            phy_tx_started <= 1'b0;
            phy_tx_done    <= 1'b0;

            if (state == SEQ_IDLE) begin
                busy_seen <= 1'b0;
            end else if (rf_busy) begin
                busy_seen <= 1'b1;
            end

            case (state)
                SEQ_IDLE: begin
                    wait_cnt <= '0;
                    if (tx_req) begin
                        phy_tx_start <= 1'b1;
                        state        <= SEQ_GAP;
                    end
                end
                SEQ_GAP: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == CNT_W'(START_GAP - 1)) begin
                        phy_tx_started <= 1'b1;
                        remaining      <= tx_len;
                        state          <= SEQ_DATA;
                    end
                end
                SEQ_DATA: begin
                    wait_cnt <= '0;
                    if (beat) begin
                        remaining <= remaining - 1'b1;
                    end
                    // empty frames finish at once
                    if (remaining == '0 || (beat && remaining == LEN_W'(1))) begin
                        phy_tx_done <= 1'b1;
                        state       <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    if (wait_cnt != '1) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                    // wait for the rf window to close, or give up if it never opened
                    if (!rf_busy && (busy_seen || wait_cnt >= CNT_W'(DRAIN_TIMEOUT))) begin
                        tx_ack <= 1'b1;
                        state  <= SEQ_ACK;
                    end
                end
                SEQ_ACK: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tx_on_detection.sv */
// per-chain detector turning FIFO empty edges and phy events into baseband, rf and chain-on windows
`timescale 1ns/1ps
`default_nettype none

module tx_on_detection import tx_rf_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] bb_rf_delay,
    input  logic [6:0] rf_end_ext,
    input  logic [6:0] chain_on_delay,
    input  logic [6:0] chain_off_delay,
    input  logic       phy_tx_start,
    input  logic       phy_tx_started,
    input  logic       phy_tx_done,
    input  logic       tx_iq_fifo_empty,
    output logic       tx_core_is_ongoing,
    output logic       tx_bb_is_ongoing,
    output logic       tx_rf_is_ongoing,
    output logic       tx_chain_on,
    output logic       pulse_tx_bb_end
);

    logic             bb_internal;
    logic [3:0]       bb_shift;
    logic             search_start;
    logic             empty_reg;
    logic             iq_running;
    logic             core_reg;
    logic             pulse_tx_bb_start;
    logic [CNT_W-1:0] delay_cnt;

    // scaled thresholds, registered once per clock
    logic [CNT_W-1:0] rf_on_top;
    logic [CNT_W-1:0] rf_off_top;
    logic [CNT_W-1:0] chain_on_top;
    logic [CNT_W-1:0] chain_off_top;

    assign tx_core_is_ongoing = core_reg | phy_tx_start;

    // keep the bb window open a few clocks so the end pulse sits inside it
    assign tx_bb_is_ongoing = bb_internal | (|bb_shift);

    assign pulse_tx_bb_start = bb_internal && !bb_shift[0];
    assign pulse_tx_bb_end   = !bb_internal && bb_shift[0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rf_on_top     <= '0;
            rf_off_top    <= '0;
            chain_on_top  <= '0;
            chain_off_top <= '0;
            bb_internal   <= 1'b0;
            bb_shift      <= '0;
            empty_reg     <= 1'b1;
            search_start  <= 1'b0;
            iq_running    <= 1'b0;
            core_reg      <= 1'b0;
        end else begin
            rf_on_top     <= CNT_W'(bb_rf_delay) * CNT_W'(COUNT_SCALE);
            rf_off_top    <= rf_on_top + CNT_W'(rf_end_ext) * CNT_W'(COUNT_SCALE);
            chain_on_top  <= CNT_W'(chain_on_delay) * CNT_W'(COUNT_SCALE);
            chain_off_top <= CNT_W'(chain_off_delay) * CNT_W'(COUNT_SCALE);

            bb_shift  <= {bb_shift[2:0], bb_internal};
            empty_reg <= tx_iq_fifo_empty;

            if (phy_tx_start) begin
                core_reg <= 1'b1;
            end else if (phy_tx_done) begin
                core_reg <= 1'b0;
            end

            // before done look for the fifo filling, after done for it running dry
            if (phy_tx_started) begin
                search_start <= 1'b1;
            end else if (phy_tx_done) begin
                search_start <= 1'b0;
            end

            if (search_start) begin
                if (empty_reg && !tx_iq_fifo_empty) begin
                    bb_internal <= 1'b1;
                end
            end else if (!empty_reg && tx_iq_fifo_empty) begin
                bb_internal <= 1'b0;
            end

            if (pulse_tx_bb_start) begin
                iq_running <= 1'b1;
            end else if (pulse_tx_bb_end) begin
                iq_running <= 1'b0;
            end
        end
    end

    // counter restarts on each bb edge, windows follow the thresholds
    always_ff @(posedge clk) begin
        if (!rstn) begin
            delay_cnt        <= '0;
            tx_rf_is_ongoing <= 1'b0;
            tx_chain_on      <= 1'b0;
        end else if (pulse_tx_bb_start || pulse_tx_bb_end) begin
            delay_cnt <= '0;
        end else begin
            if (delay_cnt != '1) begin
                delay_cnt <= delay_cnt + 1'b1;
            end

            if (iq_running && delay_cnt == rf_on_top) begin
                tx_rf_is_ongoing <= 1'b1;
            end else if (!iq_running && delay_cnt == rf_off_top) begin
                tx_rf_is_ongoing <= 1'b0;
            end

            if (iq_running && delay_cnt == chain_on_top) begin
                tx_chain_on <= 1'b1;
            end else if (!iq_running && delay_cnt == chain_off_top) begin
                tx_chain_on <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tx_iq_fifo.sv */
// per-chain IQ sample FIFO, first-word-fall-through, written by the sequencer and read by the DAC side
`timescale 1ns/1ps
`default_nettype none

module tx_iq_fifo import tx_rf_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                wr,
    input  logic [SAMPLE_W-1:0] wdata,
    input  logic                rd,
    output logic [SAMPLE_W-1:0] rdata,
    output logic                empty,
    output logic                full
);

    logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]  wr_ptr;
    logic [FIFO_AW-1:0]  rd_ptr;
    logic [FIFO_AW:0]    count;
    logic                do_wr;
    logic                do_rd;

    // writes when full and reads when empty are dropped
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign empty = (count == '0);
    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

    // head word is always on the output
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tx_rf_pkg.sv */
// shared sizes, delay scaling and sequencer state codes for the tx rf timing subsystem
`default_nettype none

package tx_rf_pkg;

    // transmit chains and sample word size per chain
    localparam int NUM_CHAINS = 2;
    localparam int SAMPLE_W = 16;

    // per-chain IQ FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // frame length in samples
    localparam int LEN_W = 10;

    // each delay setting unit is worth COUNT_SCALE clocks
    localparam int COUNT_SCALE = 4;
    localparam int CNT_W = 14;

    // clocks from phy_tx_start to phy_tx_started
    localparam int START_GAP = 3;

    // longest possible bb to rf delay plus extension, with some margin
    // used when a frame never opens an rf window
    localparam int DRAIN_TIMEOUT = (255 + 127) * COUNT_SCALE + 16;

    // frame sequencer states
    localparam logic [2:0] SEQ_IDLE = 3'd0;
    localparam logic [2:0] SEQ_GAP = 3'd1;
    localparam logic [2:0] SEQ_DATA = 3'd2;
    localparam logic [2:0] SEQ_DRAIN = 3'd3;
    localparam logic [2:0] SEQ_ACK = 3'd4;

endpackage

`default_nettype wire
